/* src/g729SeqPkg.sv */
package g729SeqPkg;

	////////////////////////////////////////////////////////////
	// Frame and subframe geometry
	////////////////////////////////////////////////////////////
	localparam int lFrame = 80;            // Samples per frame
	localparam int lSubfr = 40;            // Samples per subframe
	localparam int framesPerAnalysis = 2;  // Frame-done pulses per LP analysis

	typedef logic [6:0] subfrIdx_t;
	typedef logic [$clog2(framesPerAnalysis + 1) - 1:0] frameCount_t;

	////////////////////////////////////////////////////////////
	// Processing units
	////////////////////////////////////////////////////////////
	localparam int unitCount = 17;

	typedef logic [4:0] unitId_t;
	typedef logic [unitCount - 1:0] unitMask_t;  // One bit per unit
	typedef logic [4:0] muxSel_t;

	localparam unitId_t unitAutocorr = 5'd0;
	localparam unitId_t unitLagWindow = 5'd1;
	localparam unitId_t unitLevinson = 5'd2;
	localparam unitId_t unitAzLsp = 5'd3;
	localparam unitId_t unitLspQuant = 5'd4;
	localparam unitId_t unitIntLpc = 5'd5;
	localparam unitId_t unitIntQlpc = 5'd6;
	localparam unitId_t unitMath1 = 5'd7;
	localparam unitId_t unitPercVar = 5'd8;
	localparam unitId_t unitWeightAz = 5'd9;
	localparam unitId_t unitResidu = 5'd10;
	localparam unitId_t unitSynFilt = 5'd11;
	localparam unitId_t unitPitchOl = 5'd12;
	localparam unitId_t unitMath2 = 5'd13;
	localparam unitId_t unitMath3 = 5'd14;
	localparam unitId_t unitPitchFr3 = 5'd15;
	localparam unitId_t unitEncLag3 = 5'd16;

	////////////////////////////////////////////////////////////
	// Shared encoder registers with k in bit 0
	////////////////////////////////////////////////////////////
	typedef struct packed {
		logic aqAddr;
		logic aAddr;
		logic lTemp;
		logic temp;
		logic index;
		logic gainCode;
		logic gainPit;
		logic t0Frac;
		logic t0Max;
		logic t0Min;
		logic t0;
		logic tOp;
		logic iGamma;
		logic iSubfr;
		logic k;
	} regMask_t;

	typedef struct packed {
		regMask_t load;
		regMask_t clear;
	} regCtrl_t;

	localparam regMask_t maskNone = '0;
	localparam regMask_t maskTOp = '{tOp: 1'b1, default: 1'b0};
	localparam regMask_t maskIGamma = '{iGamma: 1'b1, default: 1'b0};
	localparam regMask_t maskPitchFr = '{t0: 1'b1, t0Frac: 1'b1, default: 1'b0};
	localparam regMask_t maskAddr = '{aAddr: 1'b1, aqAddr: 1'b1, default: 1'b0};
	localparam regMask_t maskLoopEntry = '{t0Min: 1'b1, t0Max: 1'b1, aAddr: 1'b1,
		aqAddr: 1'b1, default: 1'b0};
	localparam regMask_t maskLagEnc = '{iSubfr: 1'b1, index: 1'b1, t0Min: 1'b1,
		t0Max: 1'b1, default: 1'b0};
	localparam regMask_t maskLoopExit = '{iSubfr: 1'b1, iGamma: 1'b1, default: 1'b0};

	////////////////////////////////////////////////////////////
	// Step table word
	////////////////////////////////////////////////////////////
	localparam int stepCount = 32;

	typedef logic [$clog2(stepCount) - 1:0] stepIdx_t;

	localparam stepIdx_t loopTop = 5'd19;    // Pseudo-step outside the table
	localparam stepIdx_t loopFirst = 5'd20;
	localparam stepIdx_t loopLast = 5'd31;

	typedef struct packed {
		logic isReg;              // Tag is low for a unit step
		unitId_t unit;
		muxSel_t sel;
		regMask_t loadOnFinish;   // Pulsed with the unit's done
		logic [4:0] pad;
	} unitStep_t;

	typedef struct packed {
		logic isReg;              // Tag is high for a register step
		regMask_t load;
		regMask_t clear;
	} regStep_t;

	typedef union packed {
		unitStep_t unitStep;
		regStep_t regStep;
	} stepEntry_t;

endpackage

/* src/frameGate.sv */
`timescale 1ns/1ps

module frameGate (
	input  logic clock,
	input  logic reset,
	input  logic start,
	input  logic frameDone,
	output logic frameReady
);

	logic armed;
	g729SeqPkg::frameCount_t frameCount;

	// Stays armed once start has been seen
	always_ff @(posedge clock)
	begin
		if (reset)
			armed <= 1'b0;
		else if (start)
			armed <= 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			frameCount <= '0;
		else if (frameReady)
			frameCount <= g729SeqPkg::frameCount_t'(frameDone);  // Keep a frame landing now
		else if (armed && frameDone)
			frameCount <= frameCount + g729SeqPkg::frameCount_t'(1);
	end

	assign frameReady = (frameCount == g729SeqPkg::framesPerAnalysis);

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////
	assert property (@(posedge clock) disable iff (reset)
		frameCount <= g729SeqPkg::framesPerAnalysis);

endmodule

/* src/stepTable.sv */
`timescale 1ns/1ps

module stepTable (
	input  g729SeqPkg::stepIdx_t   step,
	output g729SeqPkg::stepEntry_t entry
);

	function automatic g729SeqPkg::stepEntry_t mkUnit(
		input g729SeqPkg::unitId_t  unitId,
		input g729SeqPkg::muxSel_t  sel,
		input g729SeqPkg::regMask_t load
	);
		g729SeqPkg::stepEntry_t e;
		e.unitStep.isReg = 1'b0;
		e.unitStep.unit = unitId;
		e.unitStep.sel = sel;
		e.unitStep.loadOnFinish = load;
		e.unitStep.pad = '0;
		return e;
	endfunction

	function automatic g729SeqPkg::stepEntry_t mkReg(
		input g729SeqPkg::regMask_t load,
		input g729SeqPkg::regMask_t clear
	);
		g729SeqPkg::stepEntry_t e;
		e.regStep.isReg = 1'b1;
		e.regStep.load = load;
		e.regStep.clear = clear;
		return e;
	endfunction

	always_comb
	begin
		case (step)
			////////////////////////////////////////////////////////////
			// LP analysis, once per frame
			5'd0: entry = mkUnit(g729SeqPkg::unitAutocorr, 5'd0, g729SeqPkg::maskNone);
			5'd1: entry = mkUnit(g729SeqPkg::unitLagWindow, 5'd1, g729SeqPkg::maskNone);
			5'd2: entry = mkUnit(g729SeqPkg::unitLevinson, 5'd2, g729SeqPkg::maskNone);
			5'd3: entry = mkUnit(g729SeqPkg::unitAzLsp, 5'd3, g729SeqPkg::maskNone);
			5'd4: entry = mkUnit(g729SeqPkg::unitLspQuant, 5'd4, g729SeqPkg::maskNone);
			5'd5: entry = mkUnit(g729SeqPkg::unitIntLpc, 5'd5, g729SeqPkg::maskNone);
			5'd6: entry = mkUnit(g729SeqPkg::unitIntQlpc, 5'd6, g729SeqPkg::maskNone);
			5'd7: entry = mkUnit(g729SeqPkg::unitMath1, 5'd7, g729SeqPkg::maskNone);
			5'd8: entry = mkUnit(g729SeqPkg::unitPercVar, 5'd8, g729SeqPkg::maskNone);

			// Weighted speech of the first then the second subframe
			5'd9: entry = mkUnit(g729SeqPkg::unitWeightAz, 5'd9, g729SeqPkg::maskNone);
			5'd10: entry = mkUnit(g729SeqPkg::unitWeightAz, 5'd10, g729SeqPkg::maskNone);
			5'd11: entry = mkUnit(g729SeqPkg::unitResidu, 5'd11, g729SeqPkg::maskNone);
			5'd12: entry = mkUnit(g729SeqPkg::unitSynFilt, 5'd12, g729SeqPkg::maskNone);
			5'd13: entry = mkUnit(g729SeqPkg::unitWeightAz, 5'd13, g729SeqPkg::maskNone);
			5'd14: entry = mkUnit(g729SeqPkg::unitWeightAz, 5'd14, g729SeqPkg::maskNone);
			5'd15: entry = mkUnit(g729SeqPkg::unitResidu, 5'd15, g729SeqPkg::maskNone);
			5'd16: entry = mkUnit(g729SeqPkg::unitSynFilt, 5'd16, g729SeqPkg::maskNone);

			5'd17: entry = mkUnit(g729SeqPkg::unitPitchOl, 5'd17, g729SeqPkg::maskTOp);
			5'd18: entry = mkUnit(g729SeqPkg::unitMath2, 5'd18, g729SeqPkg::maskLoopEntry);

			////////////////////////////////////////////////////////////
			// Loop body behind step 19 which the sequencer handles
			5'd20: entry = mkUnit(g729SeqPkg::unitWeightAz, 5'd19, g729SeqPkg::maskNone);
			5'd21: entry = mkUnit(g729SeqPkg::unitWeightAz, 5'd20, g729SeqPkg::maskNone);
			5'd22: entry = mkUnit(g729SeqPkg::unitMath3, 5'd21, g729SeqPkg::maskIGamma);
			5'd23: entry = mkUnit(g729SeqPkg::unitSynFilt, 5'd22, g729SeqPkg::maskNone);
			5'd24: entry = mkUnit(g729SeqPkg::unitSynFilt, 5'd23, g729SeqPkg::maskNone);
			5'd25: entry = mkUnit(g729SeqPkg::unitResidu, 5'd24, g729SeqPkg::maskNone);
			5'd26: entry = mkUnit(g729SeqPkg::unitSynFilt, 5'd25, g729SeqPkg::maskNone);
			5'd27: entry = mkUnit(g729SeqPkg::unitResidu, 5'd26, g729SeqPkg::maskNone);
			5'd28: entry = mkUnit(g729SeqPkg::unitSynFilt, 5'd27, g729SeqPkg::maskNone);
			5'd29: entry = mkUnit(g729SeqPkg::unitPitchFr3, 5'd28, g729SeqPkg::maskPitchFr);
			5'd30: entry = mkUnit(g729SeqPkg::unitEncLag3, 5'd29, g729SeqPkg::maskLagEnc);

			// Both closing loop actions in one word
			5'd31: entry = mkReg(g729SeqPkg::maskAddr, g729SeqPkg::maskNone);

			default: entry = mkReg(g729SeqPkg::maskNone, g729SeqPkg::maskNone);
		endcase

		// A unit number past the last unit would select no done bit at all
		assert (entry.unitStep.isReg || entry.unitStep.unit < g729SeqPkg::unitCount);
	end

endmodule

/* src/subframeLoop.sv */
`timescale 1ns/1ps

module subframeLoop (
	input  logic                  clock,
	input  logic                  reset,
	input  g729SeqPkg::regCtrl_t  regCtrl,
	output g729SeqPkg::subfrIdx_t subframeIndex,
	output logic                  loopMore
);

	// Clear wins over load, as on the shared register file
	always_ff @(posedge clock)
	begin
		if (reset)
			subframeIndex <= '0;
		else if (regCtrl.clear.iSubfr)
			subframeIndex <= '0;
		else if (regCtrl.load.iSubfr)
			subframeIndex <= subframeIndex + g729SeqPkg::subfrIdx_t'(g729SeqPkg::lSubfr);
	end

	assign loopMore = (subframeIndex < g729SeqPkg::lFrame);  // Another subframe to go

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	// Lag encoder only finishes inside the loop, so the position never overshoots
	assert property (@(posedge clock) disable iff (reset)
		subframeIndex <= g729SeqPkg::lFrame);

	// The position only moves in whole subframes
	assert property (@(posedge clock) disable iff (reset)
		(subframeIndex % g729SeqPkg::lSubfr) == 0);

endmodule

/* src/unitDispatch.sv */
`timescale 1ns/1ps

module unitDispatch (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  issue,
	input  g729SeqPkg::unitId_t   unit,
	input  g729SeqPkg::unitMask_t unitDone,
	output g729SeqPkg::unitMask_t unitGo,
	output logic                  activeDone
);

	g729SeqPkg::unitId_t activeUnit;  // Unit whose done is awaited

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			unitGo <= '0;
			activeUnit <= '0;
		end
		else
		begin
			if (issue)
			begin
				unitGo <= g729SeqPkg::unitMask_t'(1) << unit;  // One-hot go
				activeUnit <= unit;
			end
			else
			begin
				unitGo <= '0;
			end
		end
	end

	// Done bits of every other unit are ignored
	assign activeDone = unitDone[activeUnit];

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////
	assert property (@(posedge clock) disable iff (reset)
		$onehot0(unitGo));

	// Issue is held for one cycle only, so go is a single pulse
	assert property (@(posedge clock) disable iff (reset)
		(|unitGo) |=> !(|unitGo));

endmodule

/* src/encoderSequencer.sv */
`timescale 1ns/1ps

module encoderSequencer (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   start,
	input  logic                   divErr,
	input  logic                   frameReady,
	input  logic                   loopMore,
	input  logic                   activeDone,
	input  g729SeqPkg::stepEntry_t entry,
	output g729SeqPkg::stepIdx_t   step,
	output logic                   issue,
	output g729SeqPkg::unitId_t    unit,
	output g729SeqPkg::muxSel_t    mathMuxSel,
	output g729SeqPkg::regCtrl_t   regCtrl,
	output logic                   done
);

	typedef enum logic [2:0] {
		sIdle,
		sWaitFrame,
		sIssue,
		sWaitDone,
		sRegister,
		sLoopTop
	} state_t;

	state_t state, stateNext;
	g729SeqPkg::stepIdx_t stepReg, stepNext;
	g729SeqPkg::stepEntry_t cur;   // Word of the current step
	logic advance;

	// State that a newly current step starts in
	function automatic state_t landing(
		input g729SeqPkg::stepIdx_t   s,
		input g729SeqPkg::stepEntry_t e
	);
		if (s == g729SeqPkg::loopTop)
			return sLoopTop;
		else if (e.regStep.isReg)
			return sRegister;
		else
			return sIssue;
	endfunction

	////////////////////////////////////////////////////////////
	// Step pointer
	////////////////////////////////////////////////////////////
	always_comb
	begin
		advance = 1'b0;
		stepNext = stepReg;
		case (state)
			sWaitFrame:
				if (frameReady)
				begin
					advance = 1'b1;
					stepNext = '0;
				end
			sWaitDone:
				if (activeDone)
				begin
					advance = 1'b1;
					stepNext = stepReg + 1'b1;  // Step 18 runs into loopTop
				end
			sRegister:
			begin
				advance = 1'b1;
				stepNext = (stepReg == g729SeqPkg::loopLast) ? g729SeqPkg::loopTop :
					stepReg + 1'b1;
			end
			sLoopTop:
				if (loopMore)
				begin
					advance = 1'b1;
					stepNext = g729SeqPkg::loopFirst;
				end
			default: ;
		endcase
	end

	// The table is read at the step about to become current
	assign step = stepNext;
	assign unit = cur.unitStep.unit;

	////////////////////////////////////////////////////////////
	// Control FSM
	////////////////////////////////////////////////////////////
	always_comb
	begin
		stateNext = state;
		issue = 1'b0;
		done = 1'b0;
		mathMuxSel = '0;
		regCtrl = '0;
		case (state)
			sIdle:
				if (start)
					stateNext = sWaitFrame;
				else
					regCtrl.clear = '1;  // Hold every register cleared
			sIssue:
			begin
				issue = 1'b1;
				mathMuxSel = cur.unitStep.sel;
				stateNext = sWaitDone;
			end
			sWaitDone:
			begin
				mathMuxSel = cur.unitStep.sel;
				if (activeDone)
				begin
					regCtrl.load = cur.unitStep.loadOnFinish;
					if (stepNext == g729SeqPkg::loopTop)
						regCtrl.clear = g729SeqPkg::maskIGamma;  // Math2 register action
				end
			end
			sRegister:
			begin
				// Select trails the step number once loopTop has taken one
				mathMuxSel = g729SeqPkg::muxSel_t'(stepReg - 1'b1);
				regCtrl.load = cur.regStep.load;
				regCtrl.clear = cur.regStep.clear;
			end
			sLoopTop:
				if (!loopMore)
				begin
					regCtrl.clear = g729SeqPkg::maskLoopExit;
					done = !divErr;
					stateNext = sIdle;
				end
			default: ;
		endcase
		if (advance)
			stateNext = landing(stepNext, entry);
		if (divErr)
			stateNext = sIdle;  // Abort without a done pulse
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			state <= sIdle;
			stepReg <= '0;
		end
		else
		begin
			state <= stateNext;
			stepReg <= stepNext;
		end
	end

	always_ff @(posedge clock)
	begin
		if (advance)
			cur <= entry;
	end

	// Done closes the second subframe and the FSM is idle right after
	assert property (@(posedge clock) disable iff (reset)
		done |-> (state == sLoopTop) && !loopMore ##1 (state == sIdle));

endmodule

/* src/g729Sequencer.sv */
`timescale 1ns/1ps

module g729Sequencer (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  start,
	input  logic                  divErr,
	input  logic                  frameDone,
	input  g729SeqPkg::unitMask_t unitDone,
	output g729SeqPkg::unitMask_t unitGo,
	output g729SeqPkg::muxSel_t   mathMuxSel,
	output g729SeqPkg::regCtrl_t  regCtrl,
	output g729SeqPkg::subfrIdx_t subframeIndex,
	output logic                  done
);

	logic frameReady;
	logic loopMore;
	logic activeDone;
	logic issue;
	g729SeqPkg::unitId_t unit;
	g729SeqPkg::stepIdx_t step;
	g729SeqPkg::stepEntry_t entry;

	frameGate u_frameGate (
		.clock      (clock),
		.reset      (reset),
		.start      (start),
		.frameDone  (frameDone),
		.frameReady (frameReady)
	);

	stepTable u_stepTable (
		.step  (step),
		.entry (entry)
	);

	subframeLoop u_subframeLoop (
		.clock         (clock),
		.reset         (reset),
		.regCtrl       (regCtrl),
		.subframeIndex (subframeIndex),
		.loopMore      (loopMore)
	);

	unitDispatch u_unitDispatch (
		.clock      (clock),
		.reset      (reset),
		.issue      (issue),
		.unit       (unit),
		.unitDone   (unitDone),
		.unitGo     (unitGo),
		.activeDone (activeDone)
	);

	encoderSequencer u_encoderSequencer (
		.clock      (clock),
		.reset      (reset),
		.start      (start),
		.divErr     (divErr),
		.frameReady (frameReady),
		.loopMore   (loopMore),
		.activeDone (activeDone),
		.entry      (entry),
		.step       (step),
		.issue      (issue),
		.unit       (unit),
		.mathMuxSel (mathMuxSel),
		.regCtrl    (regCtrl),
		.done       (done)
	);

endmodule

/* dv/unitResponder.sv */
`timescale 1ns/1ps

module unitResponder (
	input  logic                  clock,
	input  logic                  reset,
	input  g729SeqPkg::unitMask_t unitGo,
	output g729SeqPkg::unitMask_t unitDone
);

	integer seed;
	int countdown [g729SeqPkg::unitCount];  // Cycles left until each unit answers

	// All seventeen units answer their own go after a random delay
	initial
	begin
		g729SeqPkg::unitMask_t doneNext;
		seed = 32'h81019dab;
		unitDone = '0;
		for (int i = 0; i < g729SeqPkg::unitCount; i++)
			countdown[i] = 0;
		forever
		begin
			@(negedge clock);
			doneNext = '0;
			for (int i = 0; i < g729SeqPkg::unitCount; i++)
			begin
				if (reset)
					countdown[i] = 0;
				else if (unitGo[i])
					countdown[i] = ($random(seed) & 7) + 1;  // 1 to 8 cycles
				else if (countdown[i] != 0)
				begin
					countdown[i] = countdown[i] - 1;
					doneNext[i] = (countdown[i] == 0);  // Single-cycle done
				end
			end
			unitDone = doneNext;
		end
	end

endmodule

/* dv/tbG729Sequencer.sv */
`timescale 1ns/1ps

module tbG729Sequencer;

	localparam int cycleLimit = 6 * 31 * 2 * 10 + 1000;  // Six tests of two passes plus margin
	localparam int frameGos = 41;  // 19 analysis steps and two loop bodies of 11

	// Unit numbers of steps 0 to 18 and of loop steps 20 to 30
	localparam int analysisUnits [19] = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 9, 10, 11,
		9, 9, 10, 11, 12, 13};
	localparam int loopUnits [11] = '{9, 9, 14, 11, 11, 10, 11, 10, 11, 15, 16};

	localparam g729SeqPkg::regMask_t ldTOp = '{tOp: 1'b1, default: 1'b0};
	localparam g729SeqPkg::regMask_t ldMath2 = '{t0Min: 1'b1, t0Max: 1'b1, aAddr: 1'b1,
		aqAddr: 1'b1, default: 1'b0};
	localparam g729SeqPkg::regMask_t ldMath3 = '{iGamma: 1'b1, default: 1'b0};
	localparam g729SeqPkg::regMask_t ldPitch = '{t0: 1'b1, t0Frac: 1'b1, default: 1'b0};
	localparam g729SeqPkg::regMask_t ldLag = '{iSubfr: 1'b1, index: 1'b1, t0Min: 1'b1,
		t0Max: 1'b1, default: 1'b0};
	localparam g729SeqPkg::regMask_t ldLoopEnd = '{aAddr: 1'b1, aqAddr: 1'b1, default: 1'b0};
	localparam g729SeqPkg::regMask_t exitClear = '{iSubfr: 1'b1, iGamma: 1'b1, default: 1'b0};

	logic clock;
	logic reset;
	logic start;
	logic divErr;
	logic frameDone;
	g729SeqPkg::unitMask_t unitDone;
	g729SeqPkg::unitMask_t unitGo;
	g729SeqPkg::muxSel_t mathMuxSel;
	g729SeqPkg::regCtrl_t regCtrl;
	g729SeqPkg::subfrIdx_t subframeIndex;
	logic done;

	int errorCount;
	int testCount;
	int failedTests;
	int cycleCount;

	// What the monitor saw since the last clear
	int goUnits [$];
	int goSels [$];
	int goCycles [$];
	int loopPos [$];
	g729SeqPkg::regMask_t loads [$];
	int loadSels [$];
	g729SeqPkg::regMask_t doneClear;
	int doneCount;

	always #20 clock = ~clock;

	g729Sequencer u_dut (
		.clock         (clock),
		.reset         (reset),
		.start         (start),
		.divErr        (divErr),
		.frameDone     (frameDone),
		.unitDone      (unitDone),
		.unitGo        (unitGo),
		.mathMuxSel    (mathMuxSel),
		.regCtrl       (regCtrl),
		.subframeIndex (subframeIndex),
		.done          (done)
	);

	unitResponder u_units (
		.clock    (clock),
		.reset    (reset),
		.unitGo   (unitGo),
		.unitDone (unitDone)
	);

	function automatic int goIndex(input g729SeqPkg::unitMask_t go);
		int idx;
		idx = -1;
		for (int i = 0; i < g729SeqPkg::unitCount; i++)
			if (go[i])
				idx = i;
		return idx;
	endfunction

	////////////////////////////////////////////////////////////
	// Cycle count, timeout and port monitor
	////////////////////////////////////////////////////////////
	always @(posedge clock)
	begin
		cycleCount++;
		if (cycleCount > cycleLimit)
		begin
			$display("Timeout after %0d cycles, the sequencer never finished a test", cycleLimit);
			$display("tests failed");
			$finish;
		end
		else if (!reset)
		begin
			if (unitGo != '0)
			begin
				goUnits.push_back(goIndex(unitGo));
				goSels.push_back(int'(mathMuxSel));
				goCycles.push_back(cycleCount);
				if (mathMuxSel == 5'd19)
					loopPos.push_back(int'(subframeIndex));  // First go after a loop top
			end
			if (regCtrl.load != '0)
			begin
				loads.push_back(regCtrl.load);
				loadSels.push_back(int'(mathMuxSel));
			end
			if (done)
			begin
				doneCount++;
				doneClear = regCtrl.clear;
				loopPos.push_back(int'(subframeIndex));  // Final loop top
			end
		end
	end

	task automatic checkThat(input bit ok, input string what);
		assert (ok)
		else
		begin
			$display("Error at %0d ns: %s", $time, what);
			errorCount++;
		end
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore)
			$display("Test %0d %s: ok", testCount, name);
		else
		begin
			failedTests++;
			$display("Test %0d %s: %0d errors", testCount, name, errorCount - errorsBefore);
		end
	endtask

	task automatic clearObservations();
		goUnits.delete();
		goSels.delete();
		goCycles.delete();
		loopPos.delete();
		loads.delete();
		loadSels.delete();
		doneClear = '0;
		doneCount = 0;
	endtask

	task automatic applyReset();
		@(negedge clock);
		reset = 1'b1;
		start = 1'b0;
		divErr = 1'b0;
		frameDone = 1'b0;
		repeat (2) @(negedge clock);
		reset = 1'b0;
		clearObservations();
	endtask

	task automatic raiseStart();
		@(negedge clock);
		start = 1'b1;
		@(negedge clock);
	endtask

	task automatic pulseFrameDone();
		@(negedge clock);
		frameDone = 1'b1;
		@(negedge clock);
		frameDone = 1'b0;
	endtask

	// Two frame pulses and a wait for the frame's done
	task automatic runFrame();
		int doneBefore;
		doneBefore = doneCount;
		pulseFrameDone();
		repeat (3) @(negedge clock);
		pulseFrameDone();
		do
			@(negedge clock);
		while (doneCount == doneBefore);
	endtask

	task automatic checkStepOrder();
		int expUnit;
		int expSel;
		int j;
		checkThat(goUnits.size() == frameGos,
			$sformatf("saw %0d unit issues, expected %0d", goUnits.size(), frameGos));
		for (int i = 0; i < goUnits.size() && i < frameGos; i++)
		begin
			if (i < 19)
			begin
				expUnit = analysisUnits[i];
				expSel = i;
			end
			else
			begin
				j = (i - 19) % 11;
				expUnit = loopUnits[j];
				expSel = 19 + j;
			end
			checkThat(goUnits[i] == expUnit && goSels[i] == expSel,
				$sformatf("issue %0d is unit %0d select %0d, expected unit %0d select %0d",
				i, goUnits[i], goSels[i], expUnit, expSel));
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////
	task automatic testIdleAfterReset();
		int errorsBefore;
		errorsBefore = errorCount;
		applyReset();
		repeat (3) @(negedge clock);
		checkThat(unitGo == '0, $sformatf("unitGo is %h in idle", unitGo));
		checkThat(done == 1'b0, "done is high in idle");
		checkThat(regCtrl.clear == '1, $sformatf("idle clear mask is %h", regCtrl.clear));
		checkThat(regCtrl.load == '0, $sformatf("idle load mask is %h", regCtrl.load));
		reportTest("idle after reset", errorsBefore);
	endtask

	task automatic testFrameGating();
		int errorsBefore;
		errorsBefore = errorCount;
		applyReset();
		raiseStart();
		pulseFrameDone();
		repeat (12) @(negedge clock);
		checkThat(goUnits.size() == 0, "a unit was issued after only one frameDone");
		pulseFrameDone();
		do
			@(negedge clock);
		while (goUnits.size() == 0);
		checkThat(goUnits[0] == 0 && goSels[0] == 0,
			$sformatf("first issue is unit %0d select %0d", goUnits[0], goSels[0]));
		reportTest("frame gating", errorsBefore);
	endtask

	task automatic testFrameOrder();
		int errorsBefore;
		errorsBefore = errorCount;
		applyReset();
		raiseStart();
		runFrame();
		repeat (4) @(negedge clock);
		checkStepOrder();
		checkThat(doneCount == 1, $sformatf("saw %0d done pulses", doneCount));
		checkThat(loopPos.size() == 3, $sformatf("saw %0d loop tops", loopPos.size()));
		for (int i = 0; i < loopPos.size() && i < 3; i++)
			checkThat(loopPos[i] == i * 40,
				$sformatf("loop top %0d at position %0d", i, loopPos[i]));
		checkThat(doneClear == exitClear, $sformatf("clear with done is %h", doneClear));
		reportTest("frame step order", errorsBefore);
	endtask

	task automatic testLoadOrder();
		int errorsBefore;
		int tOpSeen;
		int t0Seen;
		int t0FracSeen;
		int aAddrSeen;
		g729SeqPkg::regMask_t expLoads [$];
		int expSels [$];
		errorsBefore = errorCount;
		tOpSeen = 0;
		t0Seen = 0;
		t0FracSeen = 0;
		aAddrSeen = 0;
		expLoads = '{ldTOp, ldMath2, ldMath3, ldPitch, ldLag, ldLoopEnd,
			ldMath3, ldPitch, ldLag, ldLoopEnd};
		expSels = '{17, 18, 21, 28, 29, 30, 21, 28, 29, 30};  // Select of the loading step
		applyReset();
		raiseStart();
		runFrame();
		checkThat(loads.size() == expLoads.size(), $sformatf("saw %0d loads", loads.size()));
		for (int i = 0; i < loads.size() && i < expLoads.size(); i++)
			checkThat(loads[i] == expLoads[i] && loadSels[i] == expSels[i],
				$sformatf("load %0d is %h select %0d, expected %h select %0d",
				i, loads[i], loadSels[i], expLoads[i], expSels[i]));
		foreach (loads[i])
		begin
			if (loads[i].tOp)
				tOpSeen++;
			if (loads[i].t0)
				t0Seen++;
			if (loads[i].t0Frac)
				t0FracSeen++;
			if (loads[i].aAddr)
				aAddrSeen++;
		end
		checkThat(tOpSeen == 1 && t0Seen == 2 && t0FracSeen == 2 && aAddrSeen == 3,
			$sformatf("load counts tOp %0d t0 %0d t0Frac %0d aAddr %0d",
			tOpSeen, t0Seen, t0FracSeen, aAddrSeen));
		reportTest("register loads", errorsBefore);
	endtask

	task automatic testAbortInLoop();
		int errorsBefore;
		int issued;
		errorsBefore = errorCount;
		applyReset();
		raiseStart();
		pulseFrameDone();
		repeat (3) @(negedge clock);
		pulseFrameDone();
		do
			@(negedge clock);
		while (goUnits.size() < 24);  // Five steps into the first loop pass
		divErr = 1'b1;
		start = 1'b0;
		issued = goUnits.size();
		@(negedge clock);
		divErr = 1'b0;
		repeat (30) @(negedge clock);
		checkThat(goUnits.size() == issued,
			$sformatf("%0d units issued after abort", goUnits.size() - issued));
		checkThat(doneCount == 0, "done pulsed after abort");
		checkThat(unitGo == '0, $sformatf("unitGo is %h after abort", unitGo));
		checkThat(regCtrl.clear == '1, $sformatf("clear mask is %h after abort", regCtrl.clear));
		checkThat(regCtrl.load == '0, $sformatf("load mask is %h after abort", regCtrl.load));
		reportTest("abort in loop", errorsBefore);
	endtask

	task automatic testRepeatFrames();
		int errorsBefore;
		int firstUnits [$];
		int firstSels [$];
		int firstCycles [$];
		bit timingDiffers;
		errorsBefore = errorCount;
		timingDiffers = 1'b0;
		applyReset();
		raiseStart();
		runFrame();
		firstUnits = goUnits;
		firstSels = goSels;
		firstCycles = goCycles;
		clearObservations();
		runFrame();
		checkStepOrder();
		checkThat(goUnits.size() == firstUnits.size(), "frames issued different unit counts");
		for (int i = 0; i < goUnits.size() && i < firstUnits.size(); i++)
		begin
			checkThat(goUnits[i] == firstUnits[i] && goSels[i] == firstSels[i],
				$sformatf("issue %0d differs between frames", i));
			if (goCycles[i] - goCycles[0] != firstCycles[i] - firstCycles[0])
				timingDiffers = 1'b1;
		end
		checkThat(timingDiffers, "both frames ran with identical unit delays");
		reportTest("repeated frames", errorsBefore);
	endtask

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		start = 1'b0;
		divErr = 1'b0;
		frameDone = 1'b0;
		errorCount = 0;
		testCount = 0;
		failedTests = 0;
		testIdleAfterReset();
		testFrameGating();
		testFrameOrder();
		testLoadOrder();
		testAbortInLoop();
		testRepeatFrames();
		$display("Summary: %0d tests run, %0d with errors, %0d check errors",
			testCount, failedTests, errorCount);
		if (errorCount == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* flist.f */
src/g729SeqPkg.sv
src/frameGate.sv
src/stepTable.sv
src/subframeLoop.sv
src/unitDispatch.sv
src/encoderSequencer.sv
src/g729Sequencer.sv
dv/unitResponder.sv
dv/tbG729Sequencer.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the sequencer testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

logFile=sim.log
rm -rf obj_dir "$logFile"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tbG729Sequencer -f flist.f -o simG729 \
	&& ./obj_dir/simG729 | tee "$logFile" \
	|| { echo "Simulation build or run error"; exit 1; }

# A failing check prints the fail message, a clean run the pass message
if grep -q "tests failed" "$logFile"; then
	echo "Simulation FAILED"
	exit 1
fi
grep -q "all tests passed" "$logFile" \
	&& echo "Simulation PASSED" \
	|| { echo "Simulation FAILED, no result line"; exit 1; }
